// File: rtl/mixer_pkg.sv
/*
  shared widths, types and register map of the audio mixer
  gains are unsigned Q4.12, samples are signed two's complement
*/
`default_nettype none

package mixer_pkg;

  localparam int AUDIO_WIDTH    = 16;
  localparam int GAIN_WIDTH     = 16;
  localparam int Q_BITS         = 12; // unity gain is 1 << Q_BITS
  localparam int NR_CHANNELS    = 4;
  localparam int FIFO_DEPTH     = 4;
  localparam int REG_ADDR_WIDTH = 3;
  localparam int REG_DATA_WIDTH = 16;

  // derived widths
  localparam int PROD_WIDTH     = AUDIO_WIDTH + GAIN_WIDTH + 1;
  localparam int STATUS_WIDTH   = NR_CHANNELS + 2;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  typedef logic signed [AUDIO_WIDTH-1:0] sample_t;
  typedef logic        [GAIN_WIDTH-1:0]  gain_t;
  typedef logic    [REG_ADDR_WIDTH-1:0]  reg_addr_t;
  typedef logic    [REG_DATA_WIDTH-1:0]  reg_data_t;

  localparam sample_t SAMPLE_MAX = {1'b0, {(AUDIO_WIDTH-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(AUDIO_WIDTH-1){1'b0}}};

  //////////////////////////////
  // register map
  localparam reg_addr_t ADDR_CH_GAIN0 = 3'd0;
  localparam reg_addr_t ADDR_CH_GAIN1 = 3'd1;
  localparam reg_addr_t ADDR_CH_GAIN2 = 3'd2;
  localparam reg_addr_t ADDR_CH_GAIN3 = 3'd3;
  localparam reg_addr_t ADDR_PAN      = 3'd4; // bit i set: channel i to right bus
  localparam reg_addr_t ADDR_OUT_GAIN = 3'd5;
  localparam reg_addr_t ADDR_STATUS   = 3'd6; // ch clips, out clip, drop; w1c

  localparam gain_t GAIN_RESET = 16'd4096;

endpackage

`default_nettype wire

// File: rtl/nq_multiplier.sv
/*
  signed sample times unsigned Q-format gain, one cycle latency
  the product is shifted right by Q_BITS and clamped to the sample range
*/
`timescale 1ns/100ps
`default_nettype none

module nq_multiplier
  import mixer_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,
  input  sample_t multiplicand,
  input  gain_t   multiplier,
  output sample_t product,
  output logic    overflow
);

  logic signed [PROD_WIDTH-1:0] full_product;
  logic signed [PROD_WIDTH-1:0] shifted;
  logic [PROD_WIDTH-AUDIO_WIDTH:0] upper; // bits that must all match the sign
  logic    out_of_range;
  sample_t clamped;

  always_comb begin
    // gain gets a zero on top so it stays positive in the signed multiply
    full_product = multiplicand * $signed({1'b0, multiplier});
    shifted      = full_product >>> Q_BITS;
    upper        = shifted[PROD_WIDTH-1:AUDIO_WIDTH-1];
    out_of_range = !((&upper) || !(|upper));

    if (!out_of_range) begin
      clamped = shifted[AUDIO_WIDTH-1:0];
    end else if (shifted[PROD_WIDTH-1]) begin
      clamped = SAMPLE_MIN; // negative overflow
    end else begin
      clamped = SAMPLE_MAX;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else begin
      overflow <= out_of_range;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    product <= clamped;
  end

endmodule

`default_nettype wire

// File: rtl/mixer.sv
/*
  four channel mixer with hard left/right pan, three pipeline stages
  bus sums wrap to the sample width, only the multipliers saturate
  gains and pan are sampled as levels, change them between frames
*/
`timescale 1ns/100ps
`default_nettype none

module mixer
  import mixer_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,

  // ingress
  input  sample_t                channel_data [NR_CHANNELS],
  input  wire                    channel_valid,

  // control
  input  gain_t                  ch_gain [NR_CHANNELS],
  input  wire  [NR_CHANNELS-1:0] pan,
  input  gain_t                  out_gain,

  // egress
  output sample_t                mix_left,
  output sample_t                mix_right,
  output logic                   mix_valid,

  // status pulses
  output logic [NR_CHANNELS-1:0] ch_clip,
  output logic                   out_clip
);

  sample_t                  ch_product [NR_CHANNELS];
  logic [NR_CHANNELS-1:0]   ch_ovf;
  logic [2:0]               valid_q;    // one bit per stage

  logic signed [AUDIO_WIDTH:0] left_sum_c;
  logic signed [AUDIO_WIDTH:0] right_sum_c;
  logic signed [AUDIO_WIDTH:0] left_sum_q;
  logic signed [AUDIO_WIDTH:0] right_sum_q;

  sample_t left_bus;
  sample_t right_bus;
  logic    out_ovf_left;
  logic    out_ovf_right;

  //////////////////////////////
  // stage 1, channel gains

  for (genvar i = 0; i < NR_CHANNELS; i++) begin : g_channel
    nq_multiplier u_ch_mult (
      .clk          (clk),
      .rst_n        (rst_n),
      .multiplicand (channel_data[i]),
      .multiplier   (ch_gain[i]),
      .product      (ch_product[i]),
      .overflow     (ch_ovf[i])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], channel_valid};
    end
  end

  assign ch_clip = ch_ovf & {NR_CHANNELS{valid_q[0]}};

  //////////////////////////////
  // stage 2, pan and bus sums

  always_comb begin
    left_sum_c  = '0;
    right_sum_c = '0;
    for (int i = 0; i < NR_CHANNELS; i++) begin
      if (pan[i]) begin
        right_sum_c = right_sum_c + {ch_product[i][AUDIO_WIDTH-1], ch_product[i]};
      end else begin
        left_sum_c  = left_sum_c + {ch_product[i][AUDIO_WIDTH-1], ch_product[i]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_q[0]) begin // hold sums between frames
      left_sum_q  <= left_sum_c;
      right_sum_q <= right_sum_c;
    end
  end

  // wrap to sample width
  assign left_bus  = left_sum_q[AUDIO_WIDTH-1:0];
  assign right_bus = right_sum_q[AUDIO_WIDTH-1:0];

  //////////////////////////////
  // stage 3, output gain

  nq_multiplier u_left_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .multiplicand (left_bus),
    .multiplier   (out_gain),
    .product      (mix_left),
    .overflow     (out_ovf_left)
  );

  nq_multiplier u_right_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .multiplicand (right_bus),
    .multiplier   (out_gain),
    .product      (mix_right),
    .overflow     (out_ovf_right)
  );

  assign mix_valid = valid_q[2];
  assign out_clip  = (out_ovf_left || out_ovf_right) && valid_q[2];

endmodule

`default_nettype wire

// File: rtl/mixer_regs.sv
/*
  control and status registers, single cycle write, combinational read
  status bits are sticky, write one to clear, a new event wins over clear
  unused addresses read as zero and ignore writes
*/
`timescale 1ns/100ps
`default_nettype none

module mixer_regs
  import mixer_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,

  // register bus
  input  wire                    reg_wr,
  input  reg_addr_t              reg_addr,
  input  reg_data_t              reg_wdata,
  output reg_data_t              reg_rdata,

  // control levels to the mixer
  output gain_t                  ch_gain [NR_CHANNELS],
  output logic [NR_CHANNELS-1:0] pan,
  output gain_t                  out_gain,

  // event pulses
  input  wire  [NR_CHANNELS-1:0] ch_clip,
  input  wire                    out_clip,
  input  wire                    drop
);

  logic [STATUS_WIDTH-1:0] status;
  logic [STATUS_WIDTH-1:0] status_set;
  logic [STATUS_WIDTH-1:0] status_clr;

  assign status_set = {drop, out_clip, ch_clip};
  assign status_clr = (reg_wr && reg_addr == ADDR_STATUS) ?
                      reg_wdata[STATUS_WIDTH-1:0] : '0;

  //////////////////////////////
  // control registers

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NR_CHANNELS; i++) begin
        ch_gain[i] <= GAIN_RESET;
      end
      pan      <= '0;
      out_gain <= GAIN_RESET;
    end else if (reg_wr) begin
      case (reg_addr)
        ADDR_CH_GAIN0: ch_gain[0] <= reg_wdata;
        ADDR_CH_GAIN1: ch_gain[1] <= reg_wdata;
        ADDR_CH_GAIN2: ch_gain[2] <= reg_wdata;
        ADDR_CH_GAIN3: ch_gain[3] <= reg_wdata;
        ADDR_PAN:      pan        <= reg_wdata[NR_CHANNELS-1:0];
        ADDR_OUT_GAIN: out_gain   <= reg_wdata;
        default: ;                // status handled below
      endcase
    end
  end

  // sticky status, set has priority
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status <= '0;
    end else begin
      status <= (status & ~status_clr) | status_set;
    end
  end

  //////////////////////////////
  // read mux

  always_comb begin
    case (reg_addr)
      ADDR_CH_GAIN0: reg_rdata = ch_gain[0];
      ADDR_CH_GAIN1: reg_rdata = ch_gain[1];
      ADDR_CH_GAIN2: reg_rdata = ch_gain[2];
      ADDR_CH_GAIN3: reg_rdata = ch_gain[3];
      ADDR_PAN:      reg_rdata = reg_data_t'(pan);
      ADDR_OUT_GAIN: reg_rdata = out_gain;
      ADDR_STATUS:   reg_rdata = reg_data_t'(status);
      default:       reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/stereo_out_fifo.sv
/*
  stereo frame buffer with valid/ready egress
  ingress cannot be stalled, a frame offered while full is lost and flagged
  drop is a registered pulse one cycle after the lost frame
*/
`timescale 1ns/100ps
`default_nettype none

module stereo_out_fifo
  import mixer_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,

  // from the mixer
  input  sample_t mix_left,
  input  sample_t mix_right,
  input  wire     mix_valid,

  // egress
  output sample_t out_left,
  output sample_t out_right,
  output logic    out_valid,
  input  wire     out_ready,

  output logic    drop
);

  sample_t left_mem  [FIFO_DEPTH];
  sample_t right_mem [FIFO_DEPTH];

  logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
  logic [FIFO_CNT_WIDTH-1:0] count;

  logic full;
  logic rd_en;
  logic wr_en;

  assign out_valid = (count != '0);
  assign full      = (count == FIFO_CNT_WIDTH'(FIFO_DEPTH));
  assign rd_en     = out_valid && out_ready;
  assign wr_en     = mix_valid && (!full || rd_en); // read frees the slot

  assign out_left  = left_mem[rd_ptr];
  assign out_right = right_mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      drop   <= 1'b0;
    end else begin
      drop <= mix_valid && !wr_en;
      if (wr_en) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      left_mem[wr_ptr]  <= mix_left;
      right_mem[wr_ptr] <= mix_right;
    end
  end

endmodule

`default_nettype wire

// File: rtl/audio_mixer_top.sv
/*
  audio mixer subsystem, registers, mixer pipeline and output buffer
  latency from channel_valid to out_valid is 4 cycles with an empty buffer
*/
`timescale 1ns/100ps
`default_nettype none

module audio_mixer_top
  import mixer_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,

  input  sample_t   channel_data [NR_CHANNELS],
  input  wire       channel_valid,

  input  wire       reg_wr,
  input  reg_addr_t reg_addr,
  input  reg_data_t reg_wdata,
  output reg_data_t reg_rdata,

  output sample_t   out_left,
  output sample_t   out_right,
  output logic      out_valid,
  input  wire       out_ready
);

  gain_t                  ch_gain [NR_CHANNELS];
  logic [NR_CHANNELS-1:0] pan;
  gain_t                  out_gain;
  logic [NR_CHANNELS-1:0] ch_clip;
  logic                   out_clip;
  logic                   drop;

  sample_t mix_left;
  sample_t mix_right;
  logic    mix_valid;

  mixer_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .ch_gain   (ch_gain),
    .pan       (pan),
    .out_gain  (out_gain),
    .ch_clip   (ch_clip),
    .out_clip  (out_clip),
    .drop      (drop)
  );

  mixer u_mixer (
    .clk           (clk),
    .rst_n         (rst_n),
    .channel_data  (channel_data),
    .channel_valid (channel_valid),
    .ch_gain       (ch_gain),
    .pan           (pan),
    .out_gain      (out_gain),
    .mix_left      (mix_left),
    .mix_right     (mix_right),
    .mix_valid     (mix_valid),
    .ch_clip       (ch_clip),
    .out_clip      (out_clip)
  );

  stereo_out_fifo u_out_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .mix_left  (mix_left),
    .mix_right (mix_right),
    .mix_valid (mix_valid),
    .out_left  (out_left),
    .out_right (out_right),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .drop      (drop)
  );

endmodule

`default_nettype wire

// File: bench/mixer_properties.sv
/*
  concurrent checks on the mixer top level, attached by bind
  drop is the internal buffer pulse of the top level
*/
`timescale 1ns/100ps
`default_nettype none

module mixer_properties
  import mixer_pkg::*;
(
  input wire       clk,
  input wire       rst_n,
  input wire       channel_valid,
  input wire       out_valid,
  input wire       out_ready,
  input wire       drop,
  input sample_t   out_left,
  input sample_t   out_right,
  input reg_data_t reg_rdata
);

  a_reset_idle : assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high during reset");

  // egress holds while stalled
  a_stall_stable : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_left) && $stable(out_right))
    else $error("egress changed while stalled");

  a_frame_fate : assert property (@(posedge clk) disable iff (!rst_n)
    channel_valid |-> ##4 (out_valid || drop)) // 4 cycle pipeline plus buffer
    else $error("frame neither buffered nor dropped");

  a_rdata_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(reg_rdata))
    else $error("reg_rdata unknown");

endmodule

bind audio_mixer_top mixer_properties u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .channel_valid (channel_valid),
  .out_valid     (out_valid),
  .out_ready     (out_ready),
  .drop          (drop),
  .out_left      (out_left),
  .out_right     (out_right),
  .reg_rdata     (reg_rdata)
);

`default_nettype wire

// File: bench/tb_audio_mixer.sv
/*
  testbench for the audio mixer top level
  inputs change 10 ns after the rising edge and outputs are sampled at the falling edge
  gains only change while the pipeline and buffer are empty
*/
`timescale 1ns/100ps
`default_nettype none

module tb_audio_mixer
  import mixer_pkg::*;
;

  localparam int TIMEOUT = 2000;

  logic clk;
  logic rst_n;
  sample_t channel_data [NR_CHANNELS];
  logic channel_valid;
  logic reg_wr;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  sample_t out_left;
  sample_t out_right;
  logic out_valid;
  logic out_ready;

  gain_t model_gain [NR_CHANNELS];
  gain_t model_out_gain;
  logic [STATUS_WIDTH-1:0] expected_status;
  logic [31:0] exp_q [$];   // {left, right}
  logic [31:0] stim_state;
  logic [31:0] ready_state;
  logic random_ready;
  int sent;
  int received;
  int errors;

  audio_mixer_top UUT (
    .clk(clk), .rst_n(rst_n), .channel_data(channel_data), .channel_valid(channel_valid),
    .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .out_left(out_left), .out_right(out_right), .out_valid(out_valid), .out_ready(out_ready)
  );

  always #50 clk = !clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////
  // reference model

  function automatic sample_t scale_sample(input sample_t s, input gain_t g,
                                           output logic clip);
    longint p;
    p = (longint'(s) * longint'(g)) >>> Q_BITS;
    clip = (p > 32767) || (p < -32768);
    if (p > 32767) return SAMPLE_MAX;
    if (p < -32768) return SAMPLE_MIN;
    return sample_t'(p);
  endfunction

  function automatic void mix_model(input sample_t data [NR_CHANNELS],
                                    input logic [NR_CHANNELS-1:0] pan_bits,
                                    output sample_t left, output sample_t right,
                                    output logic [NR_CHANNELS-1:0] ch_clips,
                                    output logic o_clip);
    longint lsum;
    longint rsum;
    sample_t s;
    logic c_l;
    logic c_r;
    lsum = 0;
    rsum = 0;
    for (int i = 0; i < NR_CHANNELS; i++) begin
      s = scale_sample(data[i], model_gain[i], ch_clips[i]);
      if (pan_bits[i]) rsum = rsum + longint'(s);
      else lsum = lsum + longint'(s);
    end
    // bus sums wrap to 16 bits before the output gain
    left   = scale_sample(sample_t'(lsum), model_out_gain, c_l);
    right  = scale_sample(sample_t'(rsum), model_out_gain, c_r);
    o_clip = c_l || c_r;
  endfunction

  logic [NR_CHANNELS-1:0] model_pan;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("errors: %0d", errors + 1);
    $display("** FAIL **");
    $finish;
  endtask

  //////////////////////////////
  // drivers

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    if (addr <= ADDR_CH_GAIN3) model_gain[addr[1:0]] = data;
    if (addr == ADDR_PAN) model_pan = data[NR_CHANNELS-1:0];
    if (addr == ADDR_OUT_GAIN) model_out_gain = data;
    if (addr == ADDR_STATUS) expected_status = expected_status & ~data[STATUS_WIDTH-1:0];
    @(posedge clk);
    #10 reg_wr = 1'b0;
  endtask

  task automatic reg_check(input reg_addr_t addr, input reg_data_t exp, input string name);
    reg_addr = addr;
    #1 check_value(name, 32'(reg_rdata), 32'(exp));
  endtask

  task automatic send_frame(input sample_t data [NR_CHANNELS]);
    sample_t l;
    sample_t r;
    logic [NR_CHANNELS-1:0] cc;
    logic oc;
    mix_model(data, model_pan, l, r, cc, oc);
    exp_q.push_back({l, r});
    expected_status = expected_status | {1'b0, oc, cc};
    channel_data  = data;
    channel_valid = 1'b1;
    sent++;
    @(posedge clk);
    #10 channel_valid = 1'b0;
  endtask

  task automatic random_frame();
    sample_t d [NR_CHANNELS];
    for (int i = 0; i < NR_CHANNELS; i++) begin
      stim_state = xorshift32(stim_state);
      d[i] = sample_t'(stim_state[15:0]);
    end
    send_frame(d);
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (received != sent) begin
      @(posedge clk);
      #10 cnt++;
      if (cnt > TIMEOUT) abort_on_timeout("the output buffer to drain");
    end
  endtask

  task automatic wait_room();
    int cnt;
    cnt = 0;
    while (sent - received >= FIFO_DEPTH) begin // frames in pipeline count too
      @(posedge clk);
      #10 cnt++;
      if (cnt > TIMEOUT) abort_on_timeout("room in the output buffer");
    end
  endtask

  // scoreboard
  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("output frame arrived with no expected frame");
        errors++;
      end else begin
        check_value("out_left", 32'(out_left), 32'(signed'(exp_q[0][31:16])));
        check_value("out_right", 32'(out_right), 32'(signed'(exp_q[0][15:0])));
        void'(exp_q.pop_front());
      end
      received++;
    end
  end

  always @(posedge clk) begin
    #10;
    if (random_ready) begin
      ready_state = xorshift32(ready_state);
      out_ready   = (ready_state[1:0] != 2'b00);
    end
  end

  //////////////////////////////
  // test sequence

  initial begin
    sample_t d [NR_CHANNELS];
    int cnt;
    clk           = 1'b0;
    rst_n         = 1'b0;
    channel_valid = 1'b0;
    out_ready     = 1'b1;
    reg_wr        = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    for (int i = 0; i < NR_CHANNELS; i++) begin
      channel_data[i] = '0;
      model_gain[i]   = GAIN_RESET;
    end
    model_out_gain  = GAIN_RESET;
    model_pan       = '0;
    expected_status = '0;
    stim_state      = 32'h22f293af;
    ready_state     = xorshift32(32'h22f293af);
    random_ready    = 1'b0;
    sent            = 0;
    received        = 0;
    errors          = 0;
    repeat (10) @(posedge clk);
    #10 rst_n = 1'b1;

    // reset values
    for (int a = 0; a < 4; a++) reg_check(reg_addr_t'(a), GAIN_RESET, "ch_gain");
    reg_check(ADDR_OUT_GAIN, GAIN_RESET, "out_gain");
    reg_check(ADDR_PAN, '0, "pan");
    reg_check(ADDR_STATUS, '0, "status");
    check_value("out_valid", 32'(out_valid), 32'd0);

    // latency with unity gains
    reg_write(ADDR_PAN, 16'h0005);
    d[0] = 16'sd100;
    d[1] = -16'sd200;
    d[2] = 16'sd300;
    d[3] = 16'sd400;
    send_frame(d);
    cnt = 1; // channel_valid was sampled at the edge just passed
    while (!out_valid) begin
      @(negedge clk);
      if (!out_valid) cnt++;
      if (cnt > 20) abort_on_timeout("the first output frame");
    end
    check_value("latency", 32'(cnt), 32'd4);
    wait_drain();

    // random frames in batches with gains changed only while idle
    random_ready = 1'b1;
    for (int b = 0; b < 10; b++) begin
      for (int i = 0; i < NR_CHANNELS; i++) begin
        stim_state = xorshift32(stim_state);
        reg_write(reg_addr_t'(i), {3'b000, stim_state[12:0]});
      end
      stim_state = xorshift32(stim_state);
      reg_write(ADDR_PAN, {12'h000, stim_state[3:0]});
      stim_state = xorshift32(stim_state);
      reg_write(ADDR_OUT_GAIN, {3'b000, stim_state[12:0]});
      for (int f = 0; f < 20; f++) begin
        wait_room();
        random_frame();
      end
      wait_drain();
    end
    // idle cycles so that any surplus frame is counted
    repeat (8) @(posedge clk);
    #10;
    check_value("transferred", 32'(received), 32'(sent));
    check_value("queue_size", 32'(exp_q.size()), 32'd0);
    random_ready = 1'b0;
    out_ready = 1'b1;

    // saturation and status
    reg_write(ADDR_STATUS, 16'h003f);
    reg_write(ADDR_CH_GAIN0, 16'hffff);
    reg_write(ADDR_CH_GAIN1, 16'hffff);
    reg_write(ADDR_CH_GAIN2, 16'h1000);
    reg_write(ADDR_CH_GAIN3, 16'h2000);
    reg_write(ADDR_OUT_GAIN, 16'h8000);
    reg_write(ADDR_PAN, 16'h0005);
    d[0] = 16'sh7fff;
    d[1] = 16'sh8000;
    d[2] = 16'sh1000;
    d[3] = 16'sh0100;
    send_frame(d);
    wait_drain();
    reg_check(ADDR_STATUS, reg_data_t'(expected_status), "status");
    reg_write(ADDR_STATUS, 16'h003f);
    reg_check(ADDR_STATUS, '0, "status");

    // back-pressure and drops
    out_ready = 1'b0;
    for (int f = 0; f < 20; f++) random_frame();
    repeat (4) @(posedge clk); // pipeline depth plus drop pulse
    #10;
    expected_status[STATUS_WIDTH-1] = 1'b1;
    reg_check(ADDR_STATUS, reg_data_t'(expected_status), "status");
    check_value("out_valid", 32'(out_valid), 32'd1);
    repeat (20 - FIFO_DEPTH) void'(exp_q.pop_back());
    sent = sent - (20 - FIFO_DEPTH);
    out_ready = 1'b1;
    wait_drain();
    check_value("queue_size", 32'(exp_q.size()), 32'd0);
    repeat (2) @(posedge clk);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
rtl/mixer_pkg.sv
rtl/nq_multiplier.sv
rtl/mixer.sv
rtl/mixer_regs.sv
rtl/stereo_out_fifo.sv
rtl/audio_mixer_top.sv
bench/mixer_properties.sv
bench/tb_audio_mixer.sv

// File: run.sh
#!/bin/sh
# build and run the audio mixer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
  --top-module tb_audio_mixer -o sim_audio_mixer &&
./obj_dir/sim_audio_mixer | tee /dev/stderr | grep -q '\*\* PASS \*\*' &&
echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
